//--- beat_counter.sv
// Word counter for a line transfer, gives the current word index and flags the last beat
`timescale 1ns/100ps
`default_nettype none

module beat_counter #(
   parameter  int LINE_WORDS = intr_bus_pkg::LINE_WORDS_DEF,
   localparam int IDX_W      = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1
) (
   input  logic             bus_clk,
   input  logic             rst,
   input  logic             load,
   input  logic             dec,
   output logic [IDX_W-1:0] beat_idx,
   output logic             last_beat
);

   localparam int CNT_W = $clog2(LINE_WORDS + 1);

   logic [CNT_W-1:0] remaining;
   logic [CNT_W-1:0] used_words;

   // Remaining words, loaded with a full line and counted down per beat
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         remaining <= '0;
      end else if (load) begin
         remaining <= CNT_W'(LINE_WORDS);
      end else if (dec && (remaining != '0)) begin
         remaining <= remaining - 1'b1;
      end
   end

   // As the remaining count falls, the word position rises from zero
   assign used_words = CNT_W'(LINE_WORDS) - remaining;
   assign beat_idx   = used_words[IDX_W-1:0];

   // Only meaningful inside a data phase, so qualified by dec
   assign last_beat = dec & (remaining == CNT_W'(1));

endmodule

`default_nettype wire

//--- build.f
intr_bus_pkg.sv
intr_bus_ctrl_fsm.sv
beat_counter.sv
read_buffer.sv
bus_drive.sv
intr_detect.sv
intr_bus_top.sv
tb_intr_bus_top.sv

//--- bus_drive.sv
// Combinational bus driver, builds the outgoing word, control fields, enables and dest strobes
`timescale 1ns/100ps
`default_nettype none

module bus_drive #(
   parameter  int LINE_WORDS = intr_bus_pkg::LINE_WORDS_DEF,
   localparam int IDX_W      = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1
) (
   input  logic                                     drive_ctrl,
   input  logic                                     drive_data,
   input  logic [IDX_W-1:0]                         beat_idx,
   input  intr_bus_pkg::bus_addr_u                  mod_a,
   input  logic                                     mod_wr,
   input  intr_bus_pkg::bus_word_t [LINE_WORDS-1:0] mod_write_data,
   output intr_bus_pkg::bus_out_s                   bus_o
);
   import intr_bus_pkg::*;

   // Transfer size in bytes, always one full line
   localparam logic [11:0] LINE_BYTES = 12'(4 * LINE_WORDS);

   bus_word_t wr_word;
   logic      addr_is_kbd;

   // Low word goes out first, beat index walks up the line
   assign wr_word = mod_write_data[beat_idx];

   // Device field zero means keyboard, anything else goes to DMA/memory
   assign addr_is_kbd = (mod_a.f.device == KBD_DEVICE);

   always_comb begin
      bus_o = '0;

      // Master phase, address, size and direction
      if (drive_ctrl) begin
         bus_o.ctrl_en  = 1'b1;
         bus_o.addr     = mod_a.raw;
         bus_o.size     = LINE_BYTES;
         bus_o.rw       = mod_wr;
         bus_o.dest_kbd = addr_is_kbd;
         bus_o.dest_dma = ~addr_is_kbd;
      end

      // Write data phase
      if (drive_data) begin
         bus_o.d_en = 1'b1;
         bus_o.d    = wr_word;
      end
   end

endmodule

`default_nettype wire

//--- intr_bus_ctrl_fsm.sv
// Bus interface control FSM, sequences request, master, write, slave and read phases
`timescale 1ns/100ps
`default_nettype none

module intr_bus_ctrl_fsm (
   input  logic                      bus_clk,
   input  logic                      rst,
   input  logic                      mod_en,
   input  logic                      mod_wr,
   input  logic                      bg,
   input  logic                      ack_in,
   input  logic                      dest_in,
   input  logic                      last_beat,
   output logic                      br,
   output logic                      ack_out,
   output logic                      load,
   output logic                      dec,
   output logic                      capture,
   output logic                      drive_ctrl,
   output logic                      drive_data,
   output logic                      pending,
   output intr_bus_pkg::ctrl_state_e state
);
   import intr_bus_pkg::*;

   ctrl_state_e next_state;
   logic        req_valid;
   logic        read_posted;
   logic        read_done;

   // A new work request is ignored while a read reply is outstanding
   assign req_valid = mod_en & ~pending;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            // Incoming slave transfer has priority over our own request
            if (dest_in) begin
               next_state = SLAVE;
            end else if (req_valid) begin
               next_state = BUS_REQ;
            end
         end
         BUS_REQ: begin
            if (bg) begin
               next_state = MASTER;
            end
         end
         MASTER: begin
            if (ack_in) begin
               next_state = mod_wr ? WRITE : IDLE;
            end
         end
         WRITE: begin
            if (last_beat) begin
               next_state = IDLE;
            end
         end
         SLAVE: begin
            next_state = READ;
         end
         READ: begin
            if (last_beat) begin
               next_state = IDLE;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   // Read request accepted by memory, reply will come back as a slave transfer
   assign read_posted = (state == MASTER) & ack_in & ~mod_wr;
   assign read_done   = (state == READ) & last_beat;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         pending <= 1'b0;
      end else if (read_posted) begin
         pending <= 1'b1;
      end else if (read_done) begin
         pending <= 1'b0;
      end
   end

   // State decode into strobes
   assign br         = (state == BUS_REQ);
   assign ack_out    = (state == SLAVE);
   assign drive_ctrl = (state == MASTER);
   assign drive_data = (state == WRITE);
   assign capture    = (state == READ);

   // Counter is armed before a data phase and stepped during it
   assign load = (state == MASTER) | (state == SLAVE);
   assign dec  = drive_data | capture;

endmodule

`default_nettype wire

//--- intr_bus_pkg.sv
// Shared bus word, address, port bundle and state types for the interrupt unit bus interface
`default_nettype none

package intr_bus_pkg;

   // One data word as it travels on the shared bus
   typedef logic [31:0] bus_word_t;

   // Default cache line length in words, 16 bytes in total
   localparam int LINE_WORDS_DEF = 4;

   // Device field value that selects the keyboard
   localparam logic [2:0] KBD_DEVICE = 3'd0;

   // Decoded view of a bus address
   typedef struct packed {
      logic [10:0] upper;
      logic [2:0]  device;
      logic [1:0]  offset;
   } bus_addr_s;

   // Address is sent raw but decoded for the destination strobes
   typedef union packed {
      logic [15:0] raw;
      bus_addr_s   f;
   } bus_addr_u;

   // Everything this block drives towards the bus
   typedef struct packed {
      bus_word_t   d;
      logic [15:0] addr;
      logic [11:0] size;
      logic        rw;        // high for a write
      logic        ctrl_en;   // qualifies addr, size and rw
      logic        d_en;      // qualifies d
      logic        dest_dma;
      logic        dest_kbd;
   } bus_out_s;

   // Everything the other controllers drive towards this block
   typedef struct packed {
      bus_word_t d;
      logic      rw;
      logic      dest_dma;
      logic      dest_kbd;
   } bus_in_s;

   // One-hot controller states
   typedef enum logic [5:0] {
      IDLE    = 6'b00_0001,
      BUS_REQ = 6'b00_0010,
      MASTER  = 6'b00_0100,
      WRITE   = 6'b00_1000,
      SLAVE   = 6'b01_0000,
      READ    = 6'b10_0000
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- intr_bus_top.sv
// Top level of the interrupt unit bus interface, connects the control FSM to the datapath
`timescale 1ns/100ps
`default_nettype none

module intr_bus_top #(
   parameter int LINE_WORDS = intr_bus_pkg::LINE_WORDS_DEF
) (
   input  logic                                     bus_clk,
   input  logic                                     rst,
   // Shared bus
   output intr_bus_pkg::bus_out_s                   bus_o,
   input  intr_bus_pkg::bus_in_s                    bus_i,
   // Arbiter and other controllers
   output logic                                     br,
   input  logic                                     bg,
   output logic                                     ack_out,
   input  logic                                     ack_in,
   // Work unit
   input  logic                                     mod_en,
   input  logic                                     mod_wr,
   input  intr_bus_pkg::bus_addr_u                  mod_a,
   input  intr_bus_pkg::bus_word_t [LINE_WORDS-1:0] mod_write_data,
   output intr_bus_pkg::bus_word_t [LINE_WORDS-1:0] mod_read_data,
   output logic                                     mod_r,
   output logic                                     interrupt
);

   localparam int IDX_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

   logic             dest_in;
   logic             load;
   logic             dec;
   logic             capture;
   logic             drive_ctrl;
   logic             drive_data;
   logic             pending;
   logic             last_beat;
   logic [IDX_W-1:0] beat_idx;

   // Either destination strobe means another master is addressing us
   assign dest_in = bus_i.dest_dma | bus_i.dest_kbd;

   intr_bus_ctrl_fsm i_ctrl_fsm (
      .bus_clk    (bus_clk),
      .rst        (rst),
      .mod_en     (mod_en),
      .mod_wr     (mod_wr),
      .bg         (bg),
      .ack_in     (ack_in),
      .dest_in    (dest_in),
      .last_beat  (last_beat),
      .br         (br),
      .ack_out    (ack_out),
      .load       (load),
      .dec        (dec),
      .capture    (capture),
      .drive_ctrl (drive_ctrl),
      .drive_data (drive_data),
      .pending    (pending),
      .state      ()
   );

   beat_counter #(.LINE_WORDS(LINE_WORDS)) i_beat_counter (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .load      (load),
      .dec       (dec),
      .beat_idx  (beat_idx),
      .last_beat (last_beat)
   );

   read_buffer #(.LINE_WORDS(LINE_WORDS)) i_read_buffer (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .capture   (capture),
      .beat_idx  (beat_idx),
      .last_beat (last_beat),
      .d_in      (bus_i.d),
      .line      (mod_read_data),
      .mod_r     (mod_r)
   );

   bus_drive #(.LINE_WORDS(LINE_WORDS)) i_bus_drive (
      .drive_ctrl     (drive_ctrl),
      .drive_data     (drive_data),
      .beat_idx       (beat_idx),
      .mod_a          (mod_a),
      .mod_wr         (mod_wr),
      .mod_write_data (mod_write_data),
      .bus_o          (bus_o)
   );

   intr_detect i_intr_detect (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .dest_in   (dest_in),
      .pending   (pending),
      .interrupt (interrupt)
   );

endmodule

`default_nettype wire

//--- intr_detect.sv
// Interrupt generator, one pulse when a line arrives that was not requested
`timescale 1ns/100ps
`default_nettype none

module intr_detect (
   input  logic bus_clk,
   input  logic rst,
   input  logic dest_in,
   input  logic pending,
   output logic interrupt
);

   logic       unsolicited;
   logic [1:0] hist;

   // We are addressed as slave with no read outstanding
   assign unsolicited = dest_in & ~pending;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         hist      <= 2'b00;
         interrupt <= 1'b0;
      end else begin
         hist      <= {hist[0], unsolicited};
         // Rising edge of the history gives a single pulse
         interrupt <= hist[0] & ~hist[1];
      end
   end

endmodule

`default_nettype wire

//--- read_buffer.sv
// Line buffer filled from the bus during a slave read, plus the registered done pulse
`timescale 1ns/100ps
`default_nettype none

module read_buffer #(
   parameter  int LINE_WORDS = intr_bus_pkg::LINE_WORDS_DEF,
   localparam int IDX_W      = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1
) (
   input  logic                                         bus_clk,
   input  logic                                         rst,
   input  logic                                         capture,
   input  logic [IDX_W-1:0]                             beat_idx,
   input  logic                                         last_beat,
   input  intr_bus_pkg::bus_word_t                      d_in,
   output intr_bus_pkg::bus_word_t [LINE_WORDS-1:0]     line,
   output logic                                         mod_r
);

   logic write_done;
   logic read_done;

   // Word slot picked by the beat index, other slots hold
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         line <= '0;
      end else if (capture) begin
         line[beat_idx] <= d_in;
      end
   end

   // last_beat only rises inside a data phase, capture tells read from write
   assign write_done = last_beat & ~capture;
   assign read_done  = last_beat & capture;

   // Done pulse lands one cycle after the final word
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         mod_r <= 1'b0;
      end else begin
         mod_r <= write_done | read_done;
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the bus interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_intr_bus_top \
   -o tb_intr_bus_top
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator compile failed with status $status"
   exit 1
fi

./obj_dir/tb_intr_bus_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb_intr_bus_top.sv
// Testbench for the interrupt unit bus interface, simulate with tb_intr_bus_top as top module
`timescale 1ns/100ps
`default_nettype none

module tb_intr_bus_top;
   import intr_bus_pkg::*;

   localparam int LINE_WORDS = 4;
   localparam int NUM_TESTS  = 8;
   localparam int MAX_DLY    = 8;
   // Worst case cycles of one table entry, every delay at its maximum
   localparam int ENTRY_CYCLES   = 24 + 3 * MAX_DLY;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * ENTRY_CYCLES + 50;
   localparam logic [7:0]  RAND_DLY = 8'hFF;
   localparam logic [31:0] LFSR_POLY = 32'hB4BC_D35C;

   typedef bus_word_t [LINE_WORDS-1:0] line_t;
   typedef enum logic [1:0] {K_WRITE, K_READ, K_UNSOL} kind_e;
   typedef struct packed {
      kind_e       kind;
      logic [15:0] addr;
      logic [7:0]  bg_dly;
      logic [7:0]  ack_dly;
      logic [7:0]  reply_dly;
      logic        collide;   // mod_en raised together with dest
   } test_t;

   logic      bus_clk;
   logic      rst;
   bus_out_s  bus_o;
   bus_in_s   bus_i;
   logic      br;
   logic      bg;
   logic      ack_out;
   logic      ack_in;
   logic      mod_en;
   logic      mod_wr;
   bus_addr_u mod_a;
   line_t     mod_write_data;
   line_t     mod_read_data;
   logic      mod_r;
   logic      interrupt;

   test_t       tests [NUM_TESTS];
   logic [31:0] lfsr = 32'd6;
   int          err_cnt = 0;
   int          pass_cnt = 0;
   int          cycles = 0;

   intr_bus_top #(.LINE_WORDS(LINE_WORDS)) i_intr_bus_top (
      .bus_clk        (bus_clk),
      .rst            (rst),
      .bus_o          (bus_o),
      .bus_i          (bus_i),
      .br             (br),
      .bg             (bg),
      .ack_out        (ack_out),
      .ack_in         (ack_in),
      .mod_en         (mod_en),
      .mod_wr         (mod_wr),
      .mod_a          (mod_a),
      .mod_write_data (mod_write_data),
      .mod_read_data  (mod_read_data),
      .mod_r          (mod_r),
      .interrupt      (interrupt)
   );

   always #20 bus_clk = ~bus_clk;

   always @(posedge bus_clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error t=%0t %s exp %b got %b", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
      if (got !== exp) begin
         $display("error t=%0t %s exp %h got %h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input bus_addr_u got, input bus_addr_u exp);
      if (got !== exp) begin
         $display("error t=%0t %s exp %h got %h", $time, name, exp.raw, got.raw);
         err_cnt++;
      end
   endtask

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp) begin
         $display("error t=%0t %s exp %h got %h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   // Galois LFSR, shifts right and feeds the polynomial back on a one
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s >> 1;
      if (s[0]) begin
         lfsr_next = lfsr_next ^ LFSR_POLY;
      end
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      int i;
      val = '0;
      for (i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic random_line(output line_t line);
      int i;
      for (i = 0; i < LINE_WORDS; i++) begin
         draw_bits(32, line[i]);
      end
   endtask

   task automatic pick_delay(input logic [7:0] table_dly, output int dly);
      logic [31:0] v;
      if (table_dly == RAND_DLY) begin
         draw_bits(3, v);
         dly = int'(v);
      end else begin
         dly = int'(table_dly);
      end
   endtask

   function automatic string kind_name(input kind_e k);
      case (k)
         K_WRITE: kind_name = "write";
         K_READ:  kind_name = "read";
         default: kind_name = "unsolicited";
      endcase
   endfunction

   task automatic step();
      @(negedge bus_clk);
   endtask

   // Address phase as seen while the block owns the bus
   task automatic check_master(input bus_addr_u a, input logic wr);
      logic exp_kbd;
      exp_kbd = (a.f.device == 3'd0);
      check_bit("bus_o.ctrl_en", bus_o.ctrl_en, 1'b1);
      check_addr("bus_o.addr", bus_o.addr, a);
      check_word("bus_o.size", 32'(bus_o.size), 32'(4 * LINE_WORDS));
      check_bit("bus_o.rw", bus_o.rw, wr);
      check_bit("bus_o.dest_kbd", bus_o.dest_kbd, exp_kbd);
      check_bit("bus_o.dest_dma", bus_o.dest_dma, ~exp_kbd);
      check_bit("bus_o.d_en", bus_o.d_en, 1'b0);
   endtask

   // Work unit request, arbiter grant after bg_dly, memory ack after ack_dly
   task automatic request_phase(input bus_addr_u a, input logic wr, input int bg_dly,
                                input int ack_dly);
      int i;
      mod_en = 1'b1;
      mod_wr = wr;
      mod_a  = a;
      step();
      mod_en = 1'b0;
      check_bit("br", br, 1'b1);
      for (i = 0; i < bg_dly; i++) begin
         step();
         check_bit("br", br, 1'b1);
         check_bit("bus_o.ctrl_en", bus_o.ctrl_en, 1'b0);
      end
      bg = 1'b1;
      step();
      bg = 1'b0;
      check_bit("br", br, 1'b0);
      for (i = 0; i < ack_dly; i++) begin
         check_master(a, wr);
         step();
      end
      check_master(a, wr);
      ack_in = 1'b1;
      step();
      ack_in = 1'b0;
      check_bit("bus_o.ctrl_en", bus_o.ctrl_en, 1'b0);
   endtask

   task automatic write_phase(input line_t wdata);
      int i;
      for (i = 0; i < LINE_WORDS; i++) begin
         check_bit("bus_o.d_en", bus_o.d_en, 1'b1);
         check_word("bus_o.d", bus_o.d, wdata[i]);
         check_bit("mod_r", mod_r, 1'b0);
         step();
      end
      check_bit("bus_o.d_en", bus_o.d_en, 1'b0);
      check_bit("mod_r", mod_r, 1'b1);
      step();
      check_bit("mod_r", mod_r, 1'b0);
   endtask

   // Pending wait, a mod_en pulse here must not start a new request
   task automatic pending_wait(input int reply_dly);
      int i;
      for (i = 0; i < reply_dly; i++) begin
         check_bit("br", br, 1'b0);
         check_bit("mod_r", mod_r, 1'b0);
         check_bit("interrupt", interrupt, 1'b0);
         mod_en = (i == 0);
         step();
      end
      mod_en = 1'b0;
   endtask

   // Another controller sends a line to us as slave
   task automatic slave_phase(input line_t rdata, input logic kbd, input logic exp_intr,
                              input logic collide);
      int i;
      bus_i.dest_kbd = kbd;
      bus_i.dest_dma = ~kbd;
      bus_i.rw       = 1'b1;
      if (collide) begin
         mod_en = 1'b1;
         mod_wr = 1'b1;
      end
      step();
      bus_i.dest_kbd = 1'b0;
      bus_i.dest_dma = 1'b0;
      mod_en         = 1'b0;
      check_bit("ack_out", ack_out, 1'b1);
      check_bit("br", br, 1'b0);
      check_bit("interrupt", interrupt, 1'b0);
      step();
      for (i = 0; i < LINE_WORDS; i++) begin
         bus_i.d = rdata[i];
         check_bit("ack_out", ack_out, 1'b0);
         check_bit("br", br, 1'b0);
         check_bit("mod_r", mod_r, 1'b0);
         // Pulse lands two cycles after dest rose
         check_bit("interrupt", interrupt, exp_intr && (i == 0));
         step();
      end
      bus_i = '0;
      check_bit("mod_r", mod_r, 1'b1);
      check_line("mod_read_data", mod_read_data, rdata);
      check_bit("interrupt", interrupt, 1'b0);
      check_bit("br", br, 1'b0);
      step();
      check_bit("mod_r", mod_r, 1'b0);
   endtask

   initial begin
      test_t     t;
      line_t     line;
      bus_addr_u a;
      int        n;
      int        errs_before;
      int        bg_dly;
      int        ack_dly;
      bus_clk        = 1'b0;
      rst            = 1'b1;
      bg             = 1'b0;
      ack_in         = 1'b0;
      mod_en         = 1'b0;
      mod_wr         = 1'b0;
      mod_a          = '0;
      mod_write_data = '0;
      bus_i          = '0;

      tests[0] = '{K_WRITE, 16'h0004, 8'd0, 8'd0, 8'd0, 1'b0};
      tests[1] = '{K_WRITE, 16'h1A00, 8'd2, 8'd1, 8'd0, 1'b0};
      tests[2] = '{K_READ,  16'h0008, RAND_DLY, RAND_DLY, 8'd3, 1'b0};
      tests[3] = '{K_UNSOL, 16'h0000, 8'd0, 8'd0, 8'd0, 1'b0};
      tests[4] = '{K_READ,  16'h0C10, RAND_DLY, RAND_DLY, 8'd5, 1'b0};
      tests[5] = '{K_UNSOL, 16'h3000, 8'd0, 8'd0, 8'd0, 1'b1};
      tests[6] = '{K_WRITE, 16'h5A1C, 8'd4, 8'd3, 8'd0, 1'b0};
      tests[7] = '{K_UNSOL, 16'h0008, 8'd0, 8'd0, 8'd0, 1'b0};

      repeat (8) step();
      rst = 1'b0;
      errs_before = err_cnt;
      check_bit("br", br, 1'b0);
      check_bit("ack_out", ack_out, 1'b0);
      check_bit("bus_o.ctrl_en", bus_o.ctrl_en, 1'b0);
      check_bit("bus_o.d_en", bus_o.d_en, 1'b0);
      check_bit("bus_o.dest_kbd", bus_o.dest_kbd, 1'b0);
      check_bit("bus_o.dest_dma", bus_o.dest_dma, 1'b0);
      check_bit("mod_r", mod_r, 1'b0);
      check_bit("interrupt", interrupt, 1'b0);
      check_line("mod_read_data", mod_read_data, '0);
      $display("reset state %s", (err_cnt == errs_before) ? "passed" : "failed");
      step();

      for (n = 0; n < NUM_TESTS; n++) begin
         errs_before = err_cnt;
         t = tests[n];
         a = t.addr;
         pick_delay(t.bg_dly, bg_dly);
         pick_delay(t.ack_dly, ack_dly);
         random_line(line);
         case (t.kind)
            K_WRITE: begin
               mod_write_data = line;
               request_phase(a, 1'b1, bg_dly, ack_dly);
               write_phase(line);
            end
            K_READ: begin
               request_phase(a, 1'b0, bg_dly, ack_dly);
               pending_wait(int'(t.reply_dly));
               // Memory answers on the DMA path
               slave_phase(line, 1'b0, 1'b0, 1'b0);
            end
            default: begin
               mod_a = a;
               slave_phase(line, a.f.device == 3'd0, 1'b1, t.collide);
            end
         endcase
         step();
         check_bit("br", br, 1'b0);
         check_bit("interrupt", interrupt, 1'b0);
         step();
         if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d %s addr %h passed", n, kind_name(t.kind), t.addr);
         end else begin
            $display("test %0d %s addr %h failed with %0d errors", n, kind_name(t.kind),
                     t.addr, err_cnt - errs_before);
         end
      end

      $display("%0d of %0d tests passed, %0d errors", pass_cnt, NUM_TESTS, err_cnt);
      if (err_cnt == 0 && pass_cnt == NUM_TESTS) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
